// ==== Makefile ====
# Verilator build and run of the memory writer testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_memory_writer -Mdir obj_dir -o sim_memory_writer
	./obj_dir/sim_memory_writer | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+include
rtl/mw_pkg.sv
rtl/stream_fifo.sv
rtl/burst_planner.sv
rtl/write_engine.sv
rtl/memory_writer.sv
test/tb_memory_writer.sv

// ==== include/mw_params.svh ====
`ifndef MW_PARAMS_SVH
`define MW_PARAMS_SVH

// bus widths
`define MW_DATA_WIDTH    32
`define MW_ADDR_WIDTH    32

// longest burst in beats
`define MW_BURST_LIMIT   16

`define MW_FIFO_DEPTH    32    // two full bursts
`define MW_ACCUM_CYCLES  64    // idle cycles before a partial burst goes out

// AXI bursts must not cross this boundary
`define MW_PAGE_BYTES    4096

`endif

// ==== rtl/burst_planner.sv ====
`timescale 1ns/10ps
`include "mw_params.svh"

module burst_planner (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              plan_req,
    input  mw_pkg::plan_in_t  plan_in,
    input  mw_pkg::mem_cfg_t  cfg,
    output logic              plan_ack,
    output mw_pkg::beats_t    plan_beats
);
    import mw_pkg::*;

    localparam int PAGE_SHIFT = $clog2(`MW_PAGE_BYTES);

    words_t page_words;
    words_t high_words;
    logic   cmp_valid;

    // clipped candidates, stage 1
    beats_t fifo_c;
    beats_t remain_c;
    beats_t page_c;
    beats_t high_c;

    // ordering of the raw counts, stage 1
    logic   f_le_r;
    logic   f_le_p;
    logic   f_le_h;
    logic   r_le_p;
    logic   r_le_h;
    logic   p_le_h;

    function automatic beats_t clip(input words_t n);
        clip = (n > words_t'(`MW_BURST_LIMIT)) ? beats_t'(`MW_BURST_LIMIT) : beats_t'(n);
    endfunction

    always_comb begin
        page_words = (words_t'(`MW_PAGE_BYTES)
                     - words_t'(plan_in.cur_addr[PAGE_SHIFT-1:0])) >> AXI_AWSIZE;
        high_words = words_t'(cfg.high_addr - plan_in.cur_addr) >> AXI_AWSIZE;
    end

    always_ff @(posedge CLK) begin
        if (plan_req) begin    // plan_in is held while req is up
            fifo_c   <= clip(plan_in.fifo_words);
            remain_c <= clip(plan_in.remain_words);
            page_c   <= clip(page_words);
            high_c   <= clip(high_words);
            f_le_r   <= plan_in.fifo_words <= plan_in.remain_words;
            f_le_p   <= plan_in.fifo_words <= page_words;
            f_le_h   <= plan_in.fifo_words <= high_words;
            r_le_p   <= plan_in.remain_words <= page_words;
            r_le_h   <= plan_in.remain_words <= high_words;
            p_le_h   <= page_words <= high_words;
        end
    end

    always_ff @(posedge CLK) begin
        if (cmp_valid) begin
            if (f_le_r && f_le_p && f_le_h) begin
                plan_beats <= fifo_c;
            end else if (r_le_p && r_le_h) begin
                plan_beats <= remain_c;
            end else if (p_le_h) begin
                plan_beats <= page_c;
            end else begin
                plan_beats <= high_c;
            end
        end
    end

    // four-phase handshake with the engine
    always_ff @(posedge CLK) begin
        if (RESET) begin
            cmp_valid <= 1'b0;
            plan_ack  <= 1'b0;
        end else begin
            cmp_valid <= plan_req && !plan_ack && !cmp_valid;
            if (cmp_valid) begin
                plan_ack <= 1'b1;
            end else if (!plan_req) begin
                plan_ack <= 1'b0;
            end
        end
    end

    // engine only asks with data in the fifo and words still owed
    a_beats_in_range: assert property (
        @(posedge CLK) disable iff (RESET)
        plan_ack |-> (plan_beats != '0) && (plan_beats <= beats_t'(`MW_BURST_LIMIT))
    );

endmodule

// ==== rtl/memory_writer.sv ====
`timescale 1ns/10ps
`include "mw_params.svh"

module memory_writer (
    input  logic                                CLK,
    input  logic                                RESET,
    input  mw_pkg::word_t                       s_tdata,
    input  logic                                s_tvalid,
    output logic                                s_tready,
    output mw_pkg::aw_beat_t                    aw,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [2:0]                          awsize,
    output logic [1:0]                          awburst,
    output mw_pkg::w_beat_t                     w,
    output logic                                wvalid,
    input  logic                                wready,
    output logic [mw_pkg::BYTES_PER_WORD-1:0]   wstrb,
    input  logic                                bvalid,
    output logic                                bready,
    input  mw_pkg::mem_cfg_t                    cfg,
    input  logic                                run,
    input  logic                                stop,
    output logic                                status,
    output logic                                done,
    output mw_pkg::bytes_t                      transmitted_bytes,
    output mw_pkg::addr_t                       current_address
);
    import mw_pkg::*;

    logic     pop;
    logic     flush;
    logic     accept_en;
    logic     s_beat;
    word_t    rd_word;
    words_t   fifo_words;
    logic     plan_req;
    logic     plan_ack;
    plan_in_t plan_in;
    beats_t   plan_beats;

    assign awsize  = AXI_AWSIZE;
    assign awburst = AXI_AWBURST_INCR;
    assign wstrb   = AXI_WSTRB_ALL;    // full words only
    assign s_beat  = s_tvalid && s_tready;

    stream_fifo #(
        .DEPTH (`MW_FIFO_DEPTH)
    ) stream_fifo_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .flush      (flush),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .accept_en  (accept_en),
        .pop        (pop),
        .rd_word    (rd_word),
        .fifo_words (fifo_words)
    );

    burst_planner burst_planner_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .plan_req   (plan_req),
        .plan_in    (plan_in),
        .cfg        (cfg),
        .plan_ack   (plan_ack),
        .plan_beats (plan_beats)
    );

    write_engine write_engine_i (
        .CLK               (CLK),
        .RESET             (RESET),
        .run               (run),
        .stop              (stop),
        .cfg               (cfg),
        .fifo_words        (fifo_words),
        .rd_word           (rd_word),
        .s_beat            (s_beat),
        .pop               (pop),
        .flush             (flush),
        .accept_en         (accept_en),
        .plan_req          (plan_req),
        .plan_in           (plan_in),
        .plan_ack          (plan_ack),
        .plan_beats        (plan_beats),
        .aw                (aw),
        .awvalid           (awvalid),
        .awready           (awready),
        .w                 (w),
        .wvalid            (wvalid),
        .wready            (wready),
        .bvalid            (bvalid),
        .bready            (bready),
        .status            (status),
        .done              (done),
        .transmitted_bytes (transmitted_bytes),
        .current_address   (current_address)
    );

endmodule

// ==== rtl/mw_pkg.sv ====
`include "mw_params.svh"

package mw_pkg;

    typedef logic [`MW_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MW_DATA_WIDTH-1:0] word_t;
    typedef logic [31:0]               bytes_t;
    typedef logic [31:0]               words_t;
    typedef logic [8:0]                beats_t;   // 1 to 256
    typedef logic [7:0]                axlen_t;

    localparam int BYTES_PER_WORD = `MW_DATA_WIDTH / 8;
    localparam logic [2:0] AXI_AWSIZE = 3'($clog2(BYTES_PER_WORD));
    localparam logic [1:0] AXI_AWBURST_INCR = 2'b01;
    localparam logic [BYTES_PER_WORD-1:0] AXI_WSTRB_ALL = '1;

    typedef struct packed {
        addr_t  base_addr;
        addr_t  high_addr;    // first address past the ring
        bytes_t portion_size;
    } mem_cfg_t;

    typedef struct packed {
        addr_t  awaddr;
        axlen_t awlen;
    } aw_beat_t;

    typedef struct packed {
        word_t wdata;
        logic  wlast;
    } w_beat_t;

    // snapshot sent with a plan request
    typedef struct packed {
        words_t fifo_words;
        words_t remain_words;
        addr_t  cur_addr;
    } plan_in_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_DATA,
        PLAN,
        WRITE,
        WAIT_B
    } engine_state_e;

endpackage

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/10ps
`include "mw_params.svh"

module stream_fifo #(
    parameter int DEPTH = `MW_FIFO_DEPTH
) (
    input  logic          CLK,
    input  logic          RESET,
    input  logic          flush,
    input  mw_pkg::word_t s_tdata,
    input  logic          s_tvalid,
    output logic          s_tready,
    input  logic          accept_en,
    input  logic          pop,
    output mw_pkg::word_t rd_word,
    output mw_pkg::words_t fifo_words
);
    import mw_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        full       = (count == CNT_W'(DEPTH));
        s_tready   = accept_en && !full;
        push       = s_tvalid && s_tready;
        rd_word    = mem[rd_ptr];    // head word, read-ahead
        fifo_words = words_t'(count);
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= s_tdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // engine must only pop words it has seen in the count
    a_no_pop_when_empty: assert property (
        @(posedge CLK) disable iff (RESET)
        pop |-> (count != '0)
    );

endmodule

// ==== rtl/write_engine.sv ====
`timescale 1ns/10ps
`include "mw_params.svh"

module write_engine (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              run,
    input  logic              stop,
    input  mw_pkg::mem_cfg_t  cfg,
    input  mw_pkg::words_t    fifo_words,
    input  mw_pkg::word_t     rd_word,
    input  logic              s_beat,
    output logic              pop,
    output logic              flush,
    output logic              accept_en,
    output logic              plan_req,
    output mw_pkg::plan_in_t  plan_in,
    input  logic              plan_ack,
    input  mw_pkg::beats_t    plan_beats,
    output mw_pkg::aw_beat_t  aw,
    output logic              awvalid,
    input  logic              awready,
    output mw_pkg::w_beat_t   w,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready,
    output logic              status,
    output logic              done,
    output mw_pkg::bytes_t    transmitted_bytes,
    output mw_pkg::addr_t     current_address
);
    import mw_pkg::*;

    localparam int TIMER_W = $clog2(`MW_ACCUM_CYCLES + 1);

    engine_state_e      state;
    beats_t             beats;       // length of the burst in flight
    beats_t             beat_cnt;
    words_t             remain_words;
    addr_t              next_addr;
    logic               stop_seen;
    logic [TIMER_W-1:0] accum_timer;
    logic               accum_done;
    logic               burst_due;
    logic               w_hs;
    logic               b_hs;
    words_t             run_words;
    addr_t              run_addr;
    addr_t              addr_sum;
    bytes_t             burst_bytes;
    words_t             remain_after;

    always_comb begin
        // portion size rounded up to whole words
        run_words = words_t'(cfg.portion_size >> AXI_AWSIZE)
                  + words_t'((cfg.portion_size & bytes_t'(BYTES_PER_WORD - 1)) != '0);
        // stale address from an older ring restarts at base
        if (next_addr >= cfg.base_addr && next_addr < cfg.high_addr) begin
            run_addr = next_addr;
        end else begin
            run_addr = cfg.base_addr;
        end
        burst_bytes  = bytes_t'(beats) << AXI_AWSIZE;
        addr_sum     = next_addr + addr_t'(burst_bytes);
        remain_after = remain_words - words_t'(beats);
        w_hs         = wvalid && wready;
        b_hs         = bvalid && bready;
        accum_done   = (accum_timer == TIMER_W'(`MW_ACCUM_CYCLES));
        burst_due    = !plan_ack && ((fifo_words > words_t'(`MW_BURST_LIMIT))
                                    || (fifo_words != '0 && accum_done));
    end

    always_comb begin
        pop     = w_hs;
        flush   = run && (state == IDLE);
        w.wdata = rd_word;
        w.wlast = (beat_cnt == beats_t'(beats - 1'b1));
    end

    // cycles with a partly filled fifo and a quiet stream
    always_ff @(posedge CLK) begin
        if (RESET || s_beat || state != WAIT_DATA || fifo_words == '0) begin
            accum_timer <= '0;
        end else if (!accum_done) begin
            accum_timer <= accum_timer + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == WAIT_DATA && burst_due) begin
            plan_in.fifo_words   <= fifo_words;
            plan_in.remain_words <= remain_words;
            plan_in.cur_addr     <= next_addr;
        end
        if (state == PLAN && plan_ack) begin
            beats     <= plan_beats;
            aw.awaddr <= next_addr;
            aw.awlen  <= axlen_t'(plan_beats - 1'b1);
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state             <= IDLE;
            status            <= 1'b0;
            done              <= 1'b0;
            accept_en         <= 1'b0;
            plan_req          <= 1'b0;
            awvalid           <= 1'b0;
            wvalid            <= 1'b0;
            bready            <= 1'b0;
            stop_seen         <= 1'b0;
            beat_cnt          <= '0;
            remain_words      <= '0;
            next_addr         <= '0;
            transmitted_bytes <= '0;
            current_address   <= '0;
        end else begin
            done <= 1'b0;
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (stop && state != IDLE) begin
                stop_seen <= 1'b1;    // honoured after the burst
            end
            case (state)
                IDLE: begin
                    if (run) begin
                        state             <= WAIT_DATA;
                        status            <= 1'b1;
                        accept_en         <= 1'b1;
                        stop_seen         <= 1'b0;
                        remain_words      <= run_words;
                        next_addr         <= run_addr;
                        current_address   <= run_addr;
                        transmitted_bytes <= '0;
                    end
                end
                WAIT_DATA: begin
                    if (stop || stop_seen) begin
                        state     <= IDLE;   // nothing in flight
                        status    <= 1'b0;
                        accept_en <= 1'b0;
                    end else if (burst_due) begin
                        state    <= PLAN;
                        plan_req <= 1'b1;
                    end
                end
                PLAN: begin
                    if (plan_ack) begin
                        plan_req <= 1'b0;
                        awvalid  <= 1'b1;
                        wvalid   <= 1'b1;
                        beat_cnt <= '0;
                        state    <= WRITE;
                    end
                end
                WRITE: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (w.wlast) begin
                            wvalid <= 1'b0;
                            bready <= 1'b1;
                            state  <= WAIT_B;
                        end
                    end
                end
                WAIT_B: begin
                    if (b_hs) begin
                        bready            <= 1'b0;
                        remain_words      <= remain_after;
                        transmitted_bytes <= transmitted_bytes + burst_bytes;
                        next_addr         <= (addr_sum >= cfg.high_addr) ? cfg.base_addr
                                                                         : addr_sum;
                        if (remain_after == '0) begin
                            state     <= IDLE;
                            status    <= 1'b0;
                            accept_en <= 1'b0;
                            done      <= 1'b1;
                        end else if (stop_seen || stop) begin
                            state     <= IDLE;
                            status    <= 1'b0;
                            accept_en <= 1'b0;
                        end else begin
                            state <= WAIT_DATA;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // AW holds until the slave takes it
    a_aw_stable: assert property (
        @(posedge CLK) disable iff (RESET)
        awvalid && !awready |=> awvalid && $stable(aw)
    );

endmodule

// ==== test/tb_memory_writer.sv ====
`timescale 1ns/10ps
`include "mw_params.svh"

module tb_memory_writer;
    import mw_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int TOTAL_WORDS = 64 + 128 + 5 + 32 + 4 + 256;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;

    logic                      CLK;
    logic                      RESET;
    word_t                     s_tdata;
    logic                      s_tvalid;
    logic                      s_tready;
    aw_beat_t                  aw;
    logic                      awvalid;
    logic                      awready;
    logic [2:0]                awsize;
    logic [1:0]                awburst;
    w_beat_t                   w;
    logic                      wvalid;
    logic                      wready;
    logic [BYTES_PER_WORD-1:0] wstrb;
    logic                      bvalid;
    logic                      bready;
    mem_cfg_t                  cfg;
    logic                      run;
    logic                      stop;
    logic                      status;
    logic                      done;
    bytes_t                    transmitted_bytes;
    addr_t                     current_address;

    // stream source and slave bookkeeping
    word_t  stream_q[$];
    int     sent_cnt;
    logic   stream_on;
    addr_t  aw_addr_q[$];
    axlen_t aw_len_q[$];
    addr_t  w_addr_log[$];
    word_t  w_data_log[$];
    word_t  mem_model[addr_t];
    addr_t  w_addr;
    int     w_idx;
    int     w_beat;
    int     b_pending;
    int     burst_n;
    int     page_off;
    int     done_cnt;
    int     done_base;
    int     err_cnt;
    int     test_cnt;
    int     fail_cnt;
    string  cur_test;

    memory_writer memory_writer_i (
        .CLK (CLK), .RESET (RESET),
        .s_tdata (s_tdata), .s_tvalid (s_tvalid), .s_tready (s_tready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .awsize (awsize), .awburst (awburst),
        .w (w), .wvalid (wvalid), .wready (wready), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready),
        .cfg (cfg), .run (run), .stop (stop),
        .status (status), .done (done),
        .transmitted_bytes (transmitted_bytes), .current_address (current_address)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (RESET) begin
            s_tvalid <= 1'b0;
        end else begin
            if (s_tvalid && s_tready) begin
                sent_cnt++;
            end
            if (stream_on && sent_cnt < stream_q.size()) begin
                s_tvalid <= 1'b1;
                s_tdata  <= stream_q[sent_cnt];
            end else begin
                s_tvalid <= 1'b0;
            end
        end
    end

    // AXI slave with random stalls, W waits for its AW
    always @(posedge CLK) begin
        if (RESET) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                burst_n  = int'(aw.awlen) + 1;
                page_off = int'(aw.awaddr % `MW_PAGE_BYTES);
                aw_addr_q.push_back(aw.awaddr);
                aw_len_q.push_back(aw.awlen);
                if (burst_n > `MW_BURST_LIMIT) begin
                    $display("burst of %0d beats at %h is over the limit", burst_n, aw.awaddr);
                    err_cnt++;
                end
                if (page_off + burst_n * BYTES_PER_WORD > `MW_PAGE_BYTES) begin
                    $display("burst of %0d beats at %h crosses a 4 KB page", burst_n, aw.awaddr);
                    err_cnt++;
                end
                if (awsize != 3'd2) begin    // 4-byte beats
                    $display("MISMATCH %s awsize: expected %0d, actual %0d",
                             cur_test, 3'd2, awsize);
                    err_cnt++;
                end
                if (awburst != 2'b01) begin    // INCR
                    $display("MISMATCH %s awburst: expected %0d, actual %0d",
                             cur_test, 2'b01, awburst);
                    err_cnt++;
                end
            end
            if (wvalid && wready) begin
                w_addr = aw_addr_q[w_idx] + addr_t'(w_beat * BYTES_PER_WORD);
                mem_model[w_addr] = w.wdata;
                w_addr_log.push_back(w_addr);
                w_data_log.push_back(w.wdata);
                if (w.wlast != (w_beat == int'(aw_len_q[w_idx]))) begin
                    $display("wlast is %0b on beat %0d of burst at %h with awlen %0d",
                             w.wlast, w_beat, aw_addr_q[w_idx], aw_len_q[w_idx]);
                    err_cnt++;
                end
                if (wstrb != 4'hf) begin
                    $display("MISMATCH %s wstrb: expected %h, actual %h",
                             cur_test, 4'hf, wstrb);
                    err_cnt++;
                end
                if (w_beat == int'(aw_len_q[w_idx])) begin
                    w_idx++;
                    w_beat = 0;
                    b_pending++;
                end else begin
                    w_beat++;
                end
            end
            if (bvalid && bready) begin
                b_pending--;
            end
            awready <= ($urandom % 4) != 0;
            wready  <= (w_idx < aw_addr_q.size()) && (($urandom % 4) != 0);
            if (!(bvalid && !bready)) begin    // bvalid holds until taken
                bvalid <= (b_pending > 0) && (($urandom % 3) != 0);
            end
        end
    end

    always @(posedge CLK) begin
        if (!RESET && done) begin
            done_cnt++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bytes(input string name, input bytes_t exp, input bytes_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    function automatic mem_cfg_t make_cfg(input addr_t base, input addr_t high, input bytes_t size);
        mem_cfg_t c;
        c.base_addr    = base;
        c.high_addr    = high;
        c.portion_size = size;
        return c;
    endfunction

    // new stream words and empty slave logs, done while the DUT is idle
    task automatic prepare_run(input int nwords);
        @(negedge CLK);
        stream_q.delete();
        for (int i = 0; i < nwords; i++) begin
            stream_q.push_back($urandom);
        end
        sent_cnt = 0;
        stream_on = 1'b1;
        aw_addr_q.delete();
        aw_len_q.delete();
        w_addr_log.delete();
        w_data_log.delete();
        mem_model.delete();
        w_idx = 0;
        w_beat = 0;
    endtask

    task automatic start_run(input string name, input mem_cfg_t c);
        cur_test = name;
        @(posedge CLK);
        cfg <= c;
        run <= 1'b1;
        @(posedge CLK);
        run <= 1'b0;
        @(negedge CLK);
        done_base = done_cnt;
        if (!status) begin
            $display("%s: status did not rise after RUN", name);
            err_cnt++;
        end
    endtask

    task automatic wait_run_end(input string name, input int nwords);
        int cycles;
        cycles = 0;
        while (status && cycles < 200 * nwords + 500) begin
            @(negedge CLK);
            cycles++;
        end
        if (status) begin
            $display("%s: run still active after %0d cycles", name, cycles);
            err_cnt++;
        end
        repeat (2) @(negedge CLK);    // let the done pulse reach the counter
    endtask

    task automatic check_done(input string name, input int exp);
        if (done_cnt - done_base != exp) begin
            $display("%s: expected %0d done pulses, saw %0d", name, exp, done_cnt - done_base);
            err_cnt++;
        end
    endtask

    // word i goes to base + 4i, folded into the ring
    task automatic check_write_order(input string name, input mem_cfg_t c, input int nwords);
        addr_t exp_addr;
        int    ring;
        int    n;
        ring = int'(c.high_addr - c.base_addr);
        n = (w_addr_log.size() < nwords) ? w_addr_log.size() : nwords;
        check_bytes(name, bytes_t'(nwords * BYTES_PER_WORD),
                    bytes_t'(w_addr_log.size() * BYTES_PER_WORD));
        for (int i = 0; i < n; i++) begin
            exp_addr = c.base_addr + addr_t'((i * BYTES_PER_WORD) % ring);
            check_addr(name, exp_addr, w_addr_log[i]);
            check_word(name, stream_q[i], w_data_log[i]);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        test_cnt++;
        if (err_cnt == err0) begin
            $display("%-16s ok", name);
        end else begin
            fail_cnt++;
            $display("%-16s failed with %0d errors", name, err_cnt - err0);
        end
    endtask

    task automatic full_portion();
        mem_cfg_t c;
        int       err0;
        err0 = err_cnt;
        c = make_cfg(32'h1000, 32'h2000, 256);
        prepare_run(64);
        start_run("full_portion", c);
        wait_run_end("full_portion", 64);
        check_addr("full_portion", 32'h1000, current_address);
        check_write_order("full_portion", c, 64);
        check_bytes("full_portion", 256, transmitted_bytes);
        check_done("full_portion", 1);
        report_test("full_portion", err0);
    endtask

    task automatic burst_rules();
        mem_cfg_t c;
        int       err0;
        int       cycles;
        err0 = err_cnt;
        c = make_cfg(32'h1FC0, 32'h3000, 512);
        prepare_run(128);
        start_run("burst_rules", c);
        // short first burst so the next one runs into the page end
        cycles = 0;
        while (sent_cnt < 5 && cycles < 1000) begin
            @(negedge CLK);
            cycles++;
        end
        stream_on = 1'b0;
        while (aw_addr_q.size() == 0 && cycles < 2000) begin
            @(negedge CLK);
            cycles++;
        end
        stream_on = 1'b1;
        wait_run_end("burst_rules", 128);
        check_addr("burst_rules", 32'h1FC0, current_address);
        if (aw_addr_q.size() == 0) begin
            $display("burst_rules: no AW request seen");
            err_cnt++;
        end else begin
            check_addr("burst_rules", 32'h1FC0, aw_addr_q[0]);
        end
        check_write_order("burst_rules", c, 128);
        check_bytes("burst_rules", 512, transmitted_bytes);
        check_done("burst_rules", 1);
        report_test("burst_rules", err0);
    endtask

    task automatic short_remainder();
        mem_cfg_t c;
        int       err0;
        err0 = err_cnt;
        c = make_cfg(32'h3000, 32'h4000, 20);
        prepare_run(5);
        start_run("short_remainder", c);
        wait_run_end("short_remainder", 5);
        check_write_order("short_remainder", c, 5);
        check_bytes("short_remainder", 20, transmitted_bytes);
        check_done("short_remainder", 1);
        report_test("short_remainder", err0);
    endtask

    task automatic address_wrap();
        mem_cfg_t c;
        addr_t    a;
        int       err0;
        int       ring_words;
        err0 = err_cnt;
        c = make_cfg(32'h2000, 32'h2040, 128);
        ring_words = int'(c.high_addr - c.base_addr) / BYTES_PER_WORD;
        prepare_run(32);
        start_run("address_wrap", c);
        wait_run_end("address_wrap", 32);
        check_addr("address_wrap", 32'h2000, current_address);
        check_write_order("address_wrap", c, 32);
        // second lap overwrote the first
        for (int i = 0; i < ring_words; i++) begin
            a = c.base_addr + addr_t'(i * BYTES_PER_WORD);
            if (!mem_model.exists(a)) begin
                $display("address_wrap: nothing written at %h", a);
                err_cnt++;
            end else begin
                check_word("address_wrap", stream_q[ring_words + i], mem_model[a]);
            end
        end
        check_bytes("address_wrap", 128, transmitted_bytes);
        check_done("address_wrap", 1);
        report_test("address_wrap", err0);
    endtask

    task automatic size_rounding();
        mem_cfg_t c;
        int       err0;
        err0 = err_cnt;
        c = make_cfg(32'h4000, 32'h5000, 10);
        prepare_run(4);    // one word more than the portion needs
        start_run("size_rounding", c);
        wait_run_end("size_rounding", 4);
        check_write_order("size_rounding", c, 3);
        check_bytes("size_rounding", 12, transmitted_bytes);
        check_done("size_rounding", 1);
        report_test("size_rounding", err0);
    endtask

    task automatic stop_midway();
        mem_cfg_t c;
        int       err0;
        int       cycles;
        err0 = err_cnt;
        c = make_cfg(32'h5000, 32'h6000, 1024);
        prepare_run(256);
        start_run("stop_midway", c);
        cycles = 0;
        while (sent_cnt < 40 && cycles < 10000) begin
            @(negedge CLK);
            cycles++;
        end
        @(posedge CLK);
        stop <= 1'b1;
        @(posedge CLK);
        stop <= 1'b0;
        wait_run_end("stop_midway", 256);
        if (transmitted_bytes >= 1024) begin
            $display("stop_midway: whole portion was written despite STOP");
            err_cnt++;
        end
        check_write_order("stop_midway", c, int'(transmitted_bytes) / BYTES_PER_WORD);
        check_done("stop_midway", 0);
        @(negedge CLK);
        stream_on = 1'b0;
        report_test("stop_midway", err0);
    endtask

    initial begin
        void'($urandom(32'h51c4));
        RESET     = 1'b1;
        s_tdata   = '0;
        s_tvalid  = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        cfg       = '0;
        run       = 1'b0;
        stop      = 1'b0;
        stream_on = 1'b0;
        sent_cnt  = 0;
        w_idx     = 0;
        w_beat    = 0;
        b_pending = 0;
        done_cnt  = 0;
        done_base = 0;
        err_cnt   = 0;
        test_cnt  = 0;
        fail_cnt  = 0;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;

        full_portion();
        burst_rules();
        short_remainder();
        address_wrap();
        size_rounding();
        stop_midway();

        $display("tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
